// ==== Bender.yml ====
package:
  name: screen_game

sources:
  - design/raster_pkg.sv
  - design/game_state_fsm.sv
  - design/frame_sequencer.sv
  - design/sprite_rasterizer.sv
  - design/screen_game_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_screen_game.sv

// ==== design/frame_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * Decides which pass the rasterizer runs. pass_kind is held for a whole pass
 * and a clear pass is always followed by a pass_none state before the redraw.
 * Move strobes are only looked at in idle.
 */
module frame_sequencer (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire                    load_level,
    input  wire                    game_over,
    input  wire                    player_move,
    input  wire                    enemy_move,
    input  wire                    pass_done,
    output raster_pkg::pass_kind_t pass_kind
);
    import raster_pkg::*;

    anim_state_t state;
    anim_state_t state_next;

    always_comb begin
        state_next = state;
        unique case (state)
            idle: begin
                if (game_over) begin
                    state_next = over_wait;
                end else if (player_move || enemy_move) begin
                    state_next = erase;
                end else if (load_level) begin
                    state_next = level;
                end
            end
            erase: begin
                if (pass_done) state_next = erase_to_draw;
            end
            // Gap with pass_none so the rasterizer drops done
            erase_to_draw: begin
                if (!pass_done) state_next = draw;
            end
            draw, level: begin
                if (pass_done) state_next = idle;
            end
            over_wait: begin
                if (load_level) state_next = over_to_load;
            end
            // Redraw after the reload clear goes through the same gap
            over_to_load: begin
                if (pass_done) state_next = erase_to_draw;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        unique case (state)
            erase, over_to_load: pass_kind = pass_clear;
            draw, level:         pass_kind = pass_sprites;
            default:             pass_kind = pass_none;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/game_state_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * Game flow FSM. go is a level, each press and release steps the game.
 * Outputs are decoded from the state register, one cycle after the input edge.
 */
module game_state_fsm (
    input  wire  clk,
    input  wire  resetn,
    input  wire  go,
    input  wire  player_hit,
    output logic load_level,
    output logic level_pause,
    output logic play,
    output logic game_over
);
    import raster_pkg::*;

    game_state_t state;
    game_state_t state_next;

    // Literals are scoped where the output ports shadow them
    always_comb begin
        state_next = state;
        unique case (state)
            level_select: begin
                if (go) state_next = raster_pkg::load_level;
            end
            raster_pkg::load_level: begin
                if (!go) state_next = raster_pkg::level_pause;  // wait for release
            end
            raster_pkg::level_pause: begin
                if (go) state_next = play_start;
            end
            play_start: begin
                if (!go) state_next = raster_pkg::play;
            end
            raster_pkg::play: begin
                if (go) begin
                    state_next = pausing;  // pause wins over a hit
                end else if (player_hit) begin
                    state_next = raster_pkg::game_over;
                end
            end
            pausing: begin
                if (!go) state_next = raster_pkg::level_pause;
            end
            raster_pkg::game_over: begin
                if (go) state_next = raster_pkg::load_level;  // reload the level
            end
            default: state_next = level_select;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= level_select;
        end else begin
            state <= state_next;
        end
    end

    assign load_level  = (state == raster_pkg::load_level);
    assign level_pause = (state == raster_pkg::level_pause);
    assign play        = (state == raster_pkg::play);
    assign game_over   = (state == raster_pkg::game_over);

endmodule

`default_nettype wire

// ==== design/raster_pkg.sv ====
`default_nettype none
/*
 * Screen, sprite and colour constants shared by the game display core.
 * Squares are not clipped at the screen edge, callers keep them on screen.
 * Colours are 1 bit per channel, red in bit 2.
 */
package raster_pkg;

    // Coordinate and colour types
    typedef logic [7:0]  coord_x_t;      // 0 .. 159
    typedef logic [6:0]  coord_y_t;      // 0 .. 119
    typedef logic [2:0]  colour_t;       // {r, g, b}
    typedef logic [2:0]  sprite_side_t;  // square side, up to 7
    typedef logic [14:0] pixel_count_t;  // index within one pass

    // Screen geometry
    localparam int screen_w     = 160;
    localparam int screen_h     = 120;
    localparam int clear_pixels = screen_w * screen_h;

    // Sprite sizes
    localparam int player_width  = 3;
    localparam int num_enemies   = 3;
    localparam int enemy0_width  = 3;
    localparam int enemy1_width  = 5;
    localparam int enemy2_width  = 7;

    // Plots in one sprite pass, player first then each enemy
    localparam int sprite_pixels = player_width * player_width
                                 + enemy0_width * enemy0_width
                                 + enemy1_width * enemy1_width
                                 + enemy2_width * enemy2_width;

    // Palette
    localparam colour_t player_colour     = 3'b111;  // white
    localparam colour_t enemy0_colour     = 3'b100;  // red
    localparam colour_t enemy1_colour     = 3'b010;  // green
    localparam colour_t enemy2_colour     = 3'b001;  // blue
    localparam colour_t background_colour = 3'b000;  // black

    // Game flow
    typedef enum logic [2:0] {
        level_select,
        load_level,
        level_pause,
        play_start,
        play,
        pausing,
        game_over
    } game_state_t;

    // Drawing order
    typedef enum logic [2:0] {
        idle,
        erase,
        erase_to_draw,
        draw,
        level,
        over_wait,
        over_to_load
    } anim_state_t;

    typedef enum logic [1:0] {
        pass_none,
        pass_clear,
        pass_sprites
    } pass_kind_t;

endpackage

`default_nettype wire

// ==== design/screen_game_top.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * Display core of the game. Positions and strobes come from outside and
 * squares must stay on screen. plot going low marks the end of a pass.
 */
module screen_game_top (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       go,
    input  wire                       player_hit,
    input  wire                       player_move,
    input  wire                       enemy_move,
    input  wire raster_pkg::coord_x_t player_x,
    input  wire raster_pkg::coord_y_t player_y,
    input  wire raster_pkg::coord_x_t enemy0_x,
    input  wire raster_pkg::coord_y_t enemy0_y,
    input  wire raster_pkg::coord_x_t enemy1_x,
    input  wire raster_pkg::coord_y_t enemy1_y,
    input  wire raster_pkg::coord_x_t enemy2_x,
    input  wire raster_pkg::coord_y_t enemy2_y,
    output logic                      load_level,
    output logic                      level_pause,
    output logic                      play,
    output logic                      game_over,
    output raster_pkg::coord_x_t      pix_x,
    output raster_pkg::coord_y_t      pix_y,
    output raster_pkg::colour_t       pix_colour,
    output logic                      plot
);
    import raster_pkg::*;

    pass_kind_t pass_kind;   // sequencer to rasterizer
    logic       pass_done;   // rasterizer back to sequencer

    game_state_fsm u_state (
        .clk         (clk),
        .resetn      (resetn),
        .go          (go),
        .player_hit  (player_hit),
        .load_level  (load_level),
        .level_pause (level_pause),
        .play        (play),
        .game_over   (game_over)
    );

    frame_sequencer u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .load_level  (load_level),
        .game_over   (game_over),
        .player_move (player_move),
        .enemy_move  (enemy_move),
        .pass_done   (pass_done),
        .pass_kind   (pass_kind)
    );

    sprite_rasterizer u_raster (
        .clk        (clk),
        .resetn     (resetn),
        .pass_kind  (pass_kind),
        .player_x   (player_x),
        .enemy0_x   (enemy0_x),
        .enemy1_x   (enemy1_x),
        .enemy2_x   (enemy2_x),
        .player_y   (player_y),
        .enemy0_y   (enemy0_y),
        .enemy1_y   (enemy1_y),
        .enemy2_y   (enemy2_y),
        .pass_done  (pass_done),
        .plot       (plot),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour)
    );

endmodule

`default_nettype wire

// ==== design/sprite_rasterizer.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * One pixel per cycle onto the plot port, no back-pressure.
 * Positions are captured at pass start, squares must lie fully on screen.
 * pass_done is held until pass_kind returns to pass_none.
 */
module sprite_rasterizer (
    input  wire                    clk,
    input  wire                    resetn,
    input  wire raster_pkg::pass_kind_t pass_kind,
    input  wire raster_pkg::coord_x_t   player_x,
    input  wire raster_pkg::coord_x_t   enemy0_x,
    input  wire raster_pkg::coord_x_t   enemy1_x,
    input  wire raster_pkg::coord_x_t   enemy2_x,
    input  wire raster_pkg::coord_y_t   player_y,
    input  wire raster_pkg::coord_y_t   enemy0_y,
    input  wire raster_pkg::coord_y_t   enemy1_y,
    input  wire raster_pkg::coord_y_t   enemy2_y,
    output logic                   pass_done,
    output logic                   plot,
    output raster_pkg::coord_x_t   pix_x,
    output raster_pkg::coord_y_t   pix_y,
    output raster_pkg::colour_t    pix_colour
);
    import raster_pkg::*;

    // Index 0 is the player, 1..num_enemies the enemies
    function automatic sprite_side_t side_of(input logic [1:0] idx);
        sprite_side_t side;
        unique case (idx)
            2'd0:    side = sprite_side_t'(player_width);
            2'd1:    side = sprite_side_t'(enemy0_width);
            2'd2:    side = sprite_side_t'(enemy1_width);
            default: side = sprite_side_t'(enemy2_width);
        endcase
        return side;
    endfunction

    function automatic colour_t colour_of(input logic [1:0] idx);
        colour_t colour;
        unique case (idx)
            2'd0:    colour = player_colour;
            2'd1:    colour = enemy0_colour;
            2'd2:    colour = enemy1_colour;
            default: colour = enemy2_colour;
        endcase
        return colour;
    endfunction

    coord_x_t     cap_x [0:num_enemies];   // origins captured at start
    coord_y_t     cap_y [0:num_enemies];
    logic         clear_pass;
    pixel_count_t count;                   // plots done so far in this pass
    pixel_count_t last_count;
    logic [1:0]   sprite_idx;
    logic [1:0]   next_idx;
    sprite_side_t off_x;                   // offset inside the current square
    sprite_side_t off_y;
    sprite_side_t cur_side;
    logic         start;
    logic         last_pixel;

    assign start      = !plot && !pass_done && (pass_kind != pass_none);
    assign last_count = clear_pass ? pixel_count_t'(clear_pixels - 1)
                                   : pixel_count_t'(sprite_pixels - 1);
    assign last_pixel = plot && (count == last_count);
    assign cur_side   = side_of(sprite_idx);
    assign next_idx   = sprite_idx + 2'd1;

    // plot doubles as the busy flag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            plot      <= 1'b0;
            pass_done <= 1'b0;
        end else if (start) begin
            plot <= 1'b1;
        end else if (last_pixel) begin
            plot      <= 1'b0;
            pass_done <= 1'b1;
        end else if (pass_done && (pass_kind == pass_none)) begin
            pass_done <= 1'b0;   // ready for the next pass
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            count      <= '0;
            clear_pass <= (pass_kind == pass_clear);
            sprite_idx <= '0;
            off_x      <= '0;
            off_y      <= '0;
            cap_x[0]   <= player_x;
            cap_x[1]   <= enemy0_x;
            cap_x[2]   <= enemy1_x;
            cap_x[3]   <= enemy2_x;
            cap_y[0]   <= player_y;
            cap_y[1]   <= enemy0_y;
            cap_y[2]   <= enemy1_y;
            cap_y[3]   <= enemy2_y;
            if (pass_kind == pass_clear) begin
                pix_x      <= '0;
                pix_y      <= '0;
                pix_colour <= background_colour;
            end else begin
                pix_x      <= player_x;   // first pixel straight from the inputs
                pix_y      <= player_y;
                pix_colour <= player_colour;
            end
        end else if (plot && !last_pixel) begin
            count <= count + 1'b1;
            if (clear_pass) begin
                // Raster sweep, x fastest
                if (pix_x == coord_x_t'(screen_w - 1)) begin
                    pix_x <= '0;
                    pix_y <= pix_y + 7'd1;
                end else begin
                    pix_x <= pix_x + 8'd1;
                end
            end else if (off_x != cur_side - 3'd1) begin
                off_x <= off_x + 3'd1;
                pix_x <= pix_x + 8'd1;
            end else if (off_y != cur_side - 3'd1) begin
                off_x <= '0;                     // next row of the square
                off_y <= off_y + 3'd1;
                pix_x <= cap_x[sprite_idx];
                pix_y <= pix_y + 7'd1;
            end else begin
                // Square finished, jump to the next sprite origin
                off_x      <= '0;
                off_y      <= '0;
                sprite_idx <= next_idx;
                pix_x      <= cap_x[next_idx];
                pix_y      <= cap_y[next_idx];
                pix_colour <= colour_of(next_idx);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_pixel_model.svh ====
/*
 * Pixel model for the display core testbench, included inside the testbench module.
 * Sprite origins are packed with the player at index 0 and enemy2 at index 3.
 */
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// Side of sprite s, the player is sprite 0
function automatic int model_side(input int s);
    int side;
    case (s)
        0:       side = player_width;
        1:       side = enemy0_width;
        2:       side = enemy1_width;
        default: side = enemy2_width;
    endcase
    return side;
endfunction

function automatic colour_t model_colour(input int s);
    colour_t colour;
    case (s)
        0:       colour = player_colour;
        1:       colour = enemy0_colour;
        2:       colour = enemy1_colour;
        default: colour = enemy2_colour;
    endcase
    return colour;
endfunction

// Plots in one pass of the given kind
function automatic int pass_length(input pass_kind_t kind);
    int total;
    int s;
    total = 0;
    if (kind == pass_clear) begin
        total = screen_w * screen_h;
    end else if (kind == pass_sprites) begin
        for (s = 0; s <= num_enemies; s++) begin
            total += model_side(s) * model_side(s);
        end
    end
    return total;
endfunction

// Expected pixel number idx of a pass
function automatic void model_pixel(input pass_kind_t kind, input int idx,
                                    input coord_x_t [3:0] org_x,
                                    input coord_y_t [3:0] org_y,
                                    output coord_x_t ex, output coord_y_t ey,
                                    output colour_t ec);
    int base;
    int side;
    int off;
    int s;
    ex = coord_x_t'(idx % screen_w);   // raster order, x fastest
    ey = coord_y_t'(idx / screen_w);
    ec = background_colour;
    if (kind == pass_sprites) begin
        base = 0;
        for (s = 0; s <= num_enemies; s++) begin
            side = model_side(s);
            if (idx >= base && idx < base + side * side) begin
                off = idx - base;
                ex  = org_x[s] + coord_x_t'(off % side);
                ey  = org_y[s] + coord_y_t'(off / side);
                ec  = model_colour(s);
            end
            base += side * side;
        end
    end
endfunction

`endif

// ==== dv/tb_screen_game.sv ====
`timescale 1ns/10ps
`default_nettype none
/*
 * Testbench for the game display core. Inputs change on the falling edge.
 * Sprite positions are random from a fixed seed and always on screen.
 */
module tb_screen_game;
    import raster_pkg::*;

    `include "tb_pixel_model.svh"

    localparam int timeout_cycles = 120000;  // five clear and ten sprite passes plus margin

    logic       clk = 1'b0;
    logic       resetn;
    logic       go;
    logic       player_hit;
    logic       player_move;
    logic       enemy_move;
    coord_x_t   player_x, enemy0_x, enemy1_x, enemy2_x;
    coord_y_t   player_y, enemy0_y, enemy1_y, enemy2_y;
    logic       load_level;
    logic       level_pause;
    logic       play;
    logic       game_over;
    coord_x_t   pix_x;
    coord_y_t   pix_y;
    colour_t    pix_colour;
    logic       plot;

    logic [31:0]    lcg_state = 32'h2298_5cd3;
    int             cycle_count = 0;
    int             pixel_errors = 0;
    int             state_errors = 0;
    int             pass_errors = 0;
    pass_kind_t     expected_passes [$];   // popped when a pass starts
    pass_kind_t     cur_kind;
    logic           in_pass = 1'b0;
    pixel_count_t   plot_count;
    coord_x_t [3:0] last_x;                // inputs seen at the previous edge
    coord_y_t [3:0] last_y;
    coord_x_t [3:0] start_x;               // origins captured for this pass
    coord_y_t [3:0] start_y;

    screen_game_top u_dut (.*);

    always #50 clk = ~clk;

    task automatic check_coord_x(input coord_x_t got, input coord_x_t exp);
        if (got !== exp) begin
            pixel_errors++;
            $display("error at %0t ns: pix_x got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_coord_y(input coord_y_t got, input coord_y_t exp);
        if (got !== exp) begin
            pixel_errors++;
            $display("error at %0t ns: pix_y got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_colour(input colour_t got, input colour_t exp);
        if (got !== exp) begin
            pixel_errors++;
            $display("error at %0t ns: pix_colour got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_state_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            state_errors++;
            $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_pass_length(input pixel_count_t got, input pixel_count_t exp);
        if (got !== exp) begin
            pass_errors++;
            $display("error at %0t ns: plot count got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_levels(input logic [3:0] exp);  // {load, pause, play, over}
        check_state_bit("load_level", load_level, exp[3]);
        check_state_bit("level_pause", level_pause, exp[2]);
        check_state_bit("play", play, exp[1]);
        check_state_bit("game_over", game_over, exp[0]);
    endtask

    task automatic print_counts();
        $display("errors: pixel %0d, state %0d, pass %0d",
                 pixel_errors, state_errors, pass_errors);
    endtask

    // Value in 0 .. limit from the next LCG step
    function automatic int lcg_range(input int limit);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % (limit + 1);
    endfunction

    task automatic randomize_positions();
        player_x = coord_x_t'(lcg_range(screen_w - player_width));
        player_y = coord_y_t'(lcg_range(screen_h - player_width));
        enemy0_x = coord_x_t'(lcg_range(screen_w - enemy0_width));
        enemy0_y = coord_y_t'(lcg_range(screen_h - enemy0_width));
        enemy1_x = coord_x_t'(lcg_range(screen_w - enemy1_width));
        enemy1_y = coord_y_t'(lcg_range(screen_h - enemy1_width));
        enemy2_x = coord_x_t'(lcg_range(screen_w - enemy2_width));
        enemy2_y = coord_y_t'(lcg_range(screen_h - enemy2_width));
    endtask

    // Drive go, then check the levels one cycle later
    task automatic step_go(input logic level, input logic [3:0] exp);
        go = level;
        @(negedge clk);
        check_levels(exp);
    endtask

    task automatic pulse_move(input logic p, input logic e);
        player_move = p;
        enemy_move  = e;
        @(negedge clk);
        player_move = 1'b0;
        enemy_move  = 1'b0;
    endtask

    task automatic wait_plot(input logic level);
        while (plot !== level) @(negedge clk);
    endtask

    always @(posedge clk) begin
        coord_x_t ex;
        coord_y_t ey;
        colour_t  ec;
        if (!resetn) begin
            in_pass = 1'b0;
        end else if (plot) begin
            if (!in_pass) begin
                in_pass    = 1'b1;
                plot_count = '0;
                start_x    = last_x;   // DUT captured at the edge before the first plot
                start_y    = last_y;
                if (expected_passes.size() == 0) begin
                    pass_errors++;
                    cur_kind = pass_none;
                    $display("a pass started at %0t ns when no pass was expected", $time);
                end else begin
                    cur_kind = expected_passes.pop_front();
                end
            end
            if (int'(plot_count) < pass_length(cur_kind)) begin
                model_pixel(cur_kind, int'(plot_count), start_x, start_y, ex, ey, ec);
                check_coord_x(pix_x, ex);
                check_coord_y(pix_y, ey);
                check_colour(pix_colour, ec);
            end
            plot_count++;
        end else if (in_pass) begin
            check_pass_length(plot_count, pixel_count_t'(pass_length(cur_kind)));
            in_pass = 1'b0;
        end
        last_x = {enemy2_x, enemy1_x, enemy0_x, player_x};
        last_y = {enemy2_y, enemy1_y, enemy0_y, player_y};
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            print_counts();
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        resetn      = 1'b0;
        go          = 1'b0;
        player_hit  = 1'b0;
        player_move = 1'b0;
        enemy_move  = 1'b0;
        randomize_positions();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        step_go(1'b0, 4'b0000);
        check_state_bit("plot", plot, 1'b0);

        // Level select to load level, the level draw follows
        expected_passes.push_back(pass_sprites);
        step_go(1'b1, 4'b1000);
        repeat (3) @(negedge clk);
        step_go(1'b0, 4'b0100);
        wait_plot(1'b1);
        randomize_positions();     // too late for the running pass
        pulse_move(1'b1, 1'b1);    // ignored while drawing
        wait_plot(1'b0);
        repeat (4) @(negedge clk);

        step_go(1'b1, 4'b0000);    // play_start
        step_go(1'b0, 4'b0010);
        step_go(1'b1, 4'b0000);    // pausing
        step_go(1'b0, 4'b0100);
        step_go(1'b1, 4'b0000);
        step_go(1'b0, 4'b0010);

        // Move redraw, clear then sprites
        expected_passes.push_back(pass_clear);
        expected_passes.push_back(pass_sprites);
        pulse_move(1'b1, 1'b0);
        wait_plot(1'b1);
        pulse_move(1'b0, 1'b1);
        randomize_positions();     // used by the redraw
        wait_plot(1'b0);
        wait_plot(1'b1);
        randomize_positions();
        pulse_move(1'b1, 1'b0);
        wait_plot(1'b0);
        repeat (4) @(negedge clk);

        // Hit, then reload with go
        player_hit = 1'b1;
        @(negedge clk);
        player_hit = 1'b0;
        check_levels(4'b0001);
        expected_passes.push_back(pass_clear);
        expected_passes.push_back(pass_sprites);
        step_go(1'b1, 4'b1000);
        @(negedge clk);
        step_go(1'b0, 4'b0100);
        wait_plot(1'b1);
        pulse_move(1'b1, 1'b1);
        wait_plot(1'b0);
        wait_plot(1'b1);
        wait_plot(1'b0);
        repeat (8) @(negedge clk);
        if (expected_passes.size() != 0 || in_pass) begin
            pass_errors++;
            $display("%0d expected passes never ran", expected_passes.size());
        end

        print_counts();
        if (pixel_errors + state_errors + pass_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
design/raster_pkg.sv
design/game_state_fsm.sv
design/frame_sequencer.sv
design/sprite_rasterizer.sv
design/screen_game_top.sv
dv/tb_screen_game.sv
